/* files.f */
hw/elk_pkg.sv
hw/page_req_if.sv
hw/page_decoder.sv
hw/rom_store.sv
hw/ram_store.sv
hw/read_mux.sv
hw/elk_mem_sys.sv
tests/tb_elk_mem_sys.sv

/* Makefile */
# Verilator simulation of the memory subsystem

TOP := tb_elk_mem_sys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_elk_mem_sys.sv */
// Memory subsystem testbench
module tb_elk_mem_sys
	import elk_pkg::*;
();

	////////////////////////////////////////////////////////////////////////////
	// DUT signals and testbench state
	////////////////////////////////////////////////////////////////////////////

	logic        clk_sys;
	logic        rst;
	logic        load;
	logic        load_wr;
	store_addr_t load_addr;
	data_t       load_data;
	logic        bus_we_n;
	bus_addr_t   bus_addr;
	data_t       bus_wdata;
	data_t       bus_rdata;

	int seed;
	int errors;
	int checks_issued;
	int checks_done;

	// Read issued this cycle, result due one cycle later
	logic      rd_valid;
	logic      pend_valid;
	bus_addr_t pend_addr;
	data_t     pend_exp;

	// Model contents of both stores
	data_t     rom_model [ROM_WORDS];
	data_t     ram_model [RAM_WORDS];
	// RAM addresses written so far
	bus_addr_t wr_log [$];

	elk_mem_sys i_elk_mem_sys (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.load      (load),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.bus_we_n  (bus_we_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic data_t rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic logic [13:0] rand_off();
		int r;
		r = $random(seed);
		return r[13:0];
	endfunction

	// Expected byte for a bus address, page map on bits 18 to 14
	function automatic data_t expect_byte(input bus_addr_t a);
		logic [4:0] sel;
		logic [2:0] pg;
		data_t      b;
		sel = a[18:14];
		b = 8'h00;
		if (sel == 5'b0_01_00) begin
			b = rom_model[{3'd0, a[13:0]}];
		end else if (sel[4:2] == 3'b0_10) begin
			// Bit 14 is a mirror bit
			pg = 3'd1 + {2'b00, sel[1]};
			b = rom_model[{pg, a[13:0]}];
		end else if (sel[4:2] == 3'b0_11) begin
			pg = 3'd3 + {1'b0, sel[1:0]};
			b = rom_model[{pg, a[13:0]}];
		end else if (sel[4:3] == 2'b1_0) begin
			b = ram_model[{sel[2:0], a[13:0]}];
		end
		return b;
	endfunction

	// Only sideways RAM pages take bus writes
	function automatic void model_write(input bus_addr_t a, input data_t d);
		if (a[18:17] == 2'b10) begin
			ram_model[{a[16:14], a[13:0]}] = d;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus driver tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_read(input bus_addr_t a);
		@(posedge clk_sys);
		bus_we_n <= 1'b1;
		bus_addr <= a;
		rd_valid <= 1'b1;
		checks_issued++;
	endtask

	// First low cycle of bus_we_n
	task automatic bus_write(input bus_addr_t a, input data_t d);
		@(posedge clk_sys);
		bus_we_n  <= 1'b0;
		bus_addr  <= a;
		bus_wdata <= d;
		rd_valid  <= 1'b0;
		model_write(a, d);
	endtask

	task automatic bus_idle();
		@(posedge clk_sys);
		bus_we_n <= 1'b1;
		rd_valid <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (pend_valid) begin
			if (bus_rdata !== pend_exp) begin
				errors++;
				$display("ERR bus_rdata addr=%h got=%h exp=%h", pend_addr, bus_rdata, pend_exp);
			end
			checks_done++;
		end
		// Address on the bus now is answered after the next rising edge
		pend_valid = rd_valid;
		pend_addr  = bus_addr;
		pend_exp   = expect_byte(bus_addr);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bus_addr_t   a;
		data_t       d;
		logic [13:0] off;
		logic [13:0] offs [6];
		page_sel_t   sel;
		int          tmo;
		seed = 38609;
		errors = 0;
		checks_issued = 0;
		checks_done = 0;
		rd_valid = 1'b0;
		pend_valid = 1'b0;
		rst = 1'b1;
		load = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		bus_we_n = 1'b1;
		bus_addr = '0;
		bus_wdata = '0;

		// Reset, read data must stay zero throughout
		repeat (4) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (bus_rdata !== 8'h00) begin
				errors++;
				$display("ERR bus_rdata in reset got=%h exp=%h", bus_rdata, 8'h00);
			end
		end
		@(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		if (bus_rdata !== 8'h00) begin
			errors++;
			$display("ERR bus_rdata after reset got=%h exp=%h", bus_rdata, 8'h00);
		end

		// Download all seven ROM pages
		for (int i = 0; i < ROM_WORDS; i++) begin
			d = rand_byte();
			@(posedge clk_sys);
			load      <= 1'b1;
			load_wr   <= 1'b1;
			load_addr <= store_addr_t'(i);
			load_data <= d;
			rom_model[store_addr_t'(i)] = d;
		end
		@(posedge clk_sys);
		load    <= 1'b0;
		load_wr <= 1'b0;

		// Same offsets in every slot, so mirrors line up
		offs[0] = 14'h0000;
		offs[1] = 14'h3fff;
		for (int k = 2; k < 6; k++) begin
			offs[k] = rand_off();
		end
		// ROM slots, mirrors and unmapped slots, RAM excluded
		for (int s = 0; s < 32; s++) begin
			sel = page_sel_t'(s);
			if (sel[4:3] != 2'b10) begin
				for (int k = 0; k < 6; k++) begin
					bus_read({sel, offs[k]});
				end
			end
		end

		// Sideways RAM, single pulses on every page
		for (int p = 0; p < 8; p++) begin
			for (int k = 0; k < 12; k++) begin
				a = {2'b10, 3'(p), rand_off()};
				bus_write(a, rand_byte());
				bus_idle();
				wr_log.push_back(a);
			end
		end
		foreach (wr_log[i]) begin
			bus_read(wr_log[i]);
		end
		// Read in the cycle right after a write, same and other address
		for (int k = 0; k < 8; k++) begin
			a = {2'b10, 3'(k), rand_off()};
			bus_write(a, rand_byte());
			bus_read(a);
			bus_write(a, rand_byte());
			bus_read(wr_log[k * 5]);
			bus_read(a);
		end

		// Held-low enable, only the first data byte may land
		a = {5'b1_01_01, 14'h1234};
		bus_write(a, 8'h5a);
		for (int k = 0; k < 4; k++) begin
			@(posedge clk_sys);
			bus_wdata <= 8'ha0 + 8'(k);
		end
		bus_idle();
		bus_read(a);
		bus_write(a, 8'h3c);
		bus_idle();
		bus_read(a);

		// Writes to ROM and unmapped slots must change nothing
		for (int n = 0; n < 4; n++) begin
			off = rand_off();
			bus_write({5'b1_00_00, off}, rand_byte());
			bus_idle();
			for (int s = 0; s < 32; s++) begin
				sel = page_sel_t'(s);
				if (sel[4:3] != 2'b10) begin
					bus_write({sel, off}, rand_byte());
					bus_idle();
				end
			end
			for (int s = 0; s < 32; s++) begin
				sel = page_sel_t'(s);
				if (sel[4:3] != 2'b10 || sel == 5'b1_00_00) begin
					bus_read({sel, off});
				end
			end
		end

		// Let the last reads reach the compare process
		bus_idle();
		tmo = 0;
		while (checks_done != checks_issued && tmo < 10) begin
			@(negedge clk_sys);
			tmo++;
		end
		if (checks_done != checks_issued) begin
			errors++;
			$display("Timeout: %0d reads were never compared", checks_issued - checks_done);
		end

		$display("Reads compared: %0d, errors: %0d", checks_done, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* hw/elk_mem_sys.sv */
// Electron memory subsystem
module elk_mem_sys
	import elk_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,

	// ROM download port
	input  logic        load,
	input  logic        load_wr,
	input  store_addr_t load_addr,
	input  data_t       load_data,

	// External bus of the computer core
	input  logic        bus_we_n,
	input  bus_addr_t   bus_addr,
	input  data_t       bus_wdata,
	output data_t       bus_rdata
);

	////////////////////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////////////////////

	// Decoded page request
	page_req_if req ();

	// Store outputs into the mux
	data_t rom_q;
	data_t ram_q;

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	// Bus capture and page decode
	page_decoder i_page_decoder (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.bus_we_n  (bus_we_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.req       (req.dec)
	);

	// Seven ROM pages
	rom_store #(
		.WORDS (ROM_WORDS)
	) i_rom_store (
		.clk_sys   (clk_sys),
		.load      (load),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.req       (req.rom),
		.q         (rom_q)
	);

	// Eight sideways RAM pages
	ram_store #(
		.WORDS (RAM_WORDS)
	) i_ram_store (
		.clk_sys (clk_sys),
		.req     (req.ram),
		.q       (ram_q)
	);

	// Output select
	read_mux i_read_mux (
		.clk_sys (clk_sys),
		.rst     (rst),
		.req     (req.mux),
		.rom_q   (rom_q),
		.ram_q   (ram_q),
		.rdata   (bus_rdata)
	);

endmodule

/* hw/read_mux.sv */
// Read data select
module read_mux
	import elk_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst,
	page_req_if.mux req,
	input  data_t   rom_q,
	input  data_t   ram_q,
	output data_t   rdata
);

	////////////////////////////////////////////////////////////////////////////
	// Kind pipeline
	////////////////////////////////////////////////////////////////////////////

	// Delayed one cycle to match the store address registers
	bank_kind_t kind_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kind_q <= BANK_NONE;
		end else begin
			kind_q <= req.kind;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (kind_q)
			BANK_ROM: begin
				rdata = rom_q;
			end
			BANK_RAM: begin
				rdata = ram_q;
			end
			// Unmapped pages read as zero
			default: begin
				rdata = '0;
			end
		endcase
	end

endmodule

/* hw/ram_store.sv */
// Sideways RAM store
module ram_store
	import elk_pkg::*;
#(
	parameter int WORDS = RAM_WORDS
) (
	input  logic    clk_sys,
	page_req_if.ram req,
	output data_t   q
);

	////////////////////////////////////////////////////////////////////////////
	// Array
	////////////////////////////////////////////////////////////////////////////

	data_t       mem [WORDS];
	store_addr_t addr_q;
	logic        we;

	// One write per falling edge, RAM pages only
	assign we = req.wr_stb && (req.kind == BANK_RAM);

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[req.ram_addr] <= req.wdata;
		end
		// Read address always follows the bus
		addr_q <= req.ram_addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// New data on read during write
	assign q = mem[addr_q];

	// Strobes decoded to ROM or unmapped pages leave the word untouched
	a_no_foreign_write: assert property (
		@(posedge clk_sys)
		(req.wr_stb && req.kind != BANK_RAM)
			|=> mem[$past(req.ram_addr)] == $past(mem[req.ram_addr])
	);

endmodule

/* hw/rom_store.sv */
// ROM store with download port
module rom_store
	import elk_pkg::*;
#(
	parameter int WORDS = ROM_WORDS
) (
	input  logic        clk_sys,
	input  logic        load,
	input  logic        load_wr,
	input  store_addr_t load_addr,
	input  data_t       load_data,
	page_req_if.rom     req,
	output data_t       q
);

	////////////////////////////////////////////////////////////////////////////
	// Array
	////////////////////////////////////////////////////////////////////////////

	data_t       mem [WORDS];
	store_addr_t addr;
	store_addr_t addr_q;
	logic        we;

	// Download owns the single port while load is high
	assign addr = load ? load_addr : req.rom_addr;

	// Writes only through the download port
	assign we = load & load_wr;

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= load_data;
		end
		// Address register, like a block RAM input stage
		addr_q <= addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Registered address, so a write at the same edge reads back new data
	assign q = mem[addr_q];

	// Download index must stay inside the configured depth
	a_wr_in_range: assert property (
		@(posedge clk_sys)
		we |-> (int'(addr) < WORDS)
	);

endmodule

/* hw/page_decoder.sv */
// Bus page decoder
module page_decoder
	import elk_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	input  logic      bus_we_n,
	input  bus_addr_t bus_addr,
	input  data_t     bus_wdata,
	page_req_if.dec   req
);

	////////////////////////////////////////////////////////////////////////////
	// Write edge detection
	////////////////////////////////////////////////////////////////////////////

	// Write enable seen at the previous edge
	logic prev_we_n;
	logic wr_stb;

	// Starts high so a low bus_we_n out of reset still counts as one edge
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			prev_we_n <= 1'b1;
		end else begin
			prev_we_n <= bus_we_n;
		end
	end

	// High in the first low cycle only
	assign wr_stb = prev_we_n & ~bus_we_n;

	////////////////////////////////////////////////////////////////////////////
	// Page decode
	////////////////////////////////////////////////////////////////////////////

	page_sel_t  sel;
	page_num_t  rom_pg;
	page_num_t  ram_pg;
	bank_kind_t kind;

	// Top five address bits pick the slot
	assign sel = bus_addr[BUS_AW-1:PAGE_BITS];

	always_comb begin
		// Unmapped unless a slot matches
		kind   = BANK_NONE;
		rom_pg = ROM_PG_SWR;
		ram_pg = '0;

		if (sel == PG_SWR_ROM) begin
			kind   = BANK_ROM;
			rom_pg = ROM_PG_SWR;
		end else if (sel[PAGE_SEL_W-1 -: 3] == GRP_OS_BASIC) begin
			// Bit 15 picks OS or BASIC, bit 14 is a mirror
			kind   = BANK_ROM;
			rom_pg = ROM_PG_OS + page_num_t'(sel[1]);
		end else if (sel[PAGE_SEL_W-1 -: 3] == GRP_HIGH_ROM) begin
			// Pages 3 to 6
			kind   = BANK_ROM;
			rom_pg = ROM_PG_HIGH + page_num_t'(sel[1:0]);
		end else if (sel[PAGE_SEL_W-1 -: 2] == GRP_SWRAM) begin
			// Eight RAM pages straight from bits 16 to 14
			kind   = BANK_RAM;
			ram_pg = sel[PAGE_NUM_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Request outputs
	////////////////////////////////////////////////////////////////////////////

	assign req.kind     = kind;
	// Page number on top, offset below
	assign req.rom_addr = {rom_pg, bus_addr[PAGE_BITS-1:0]};
	assign req.ram_addr = {ram_pg, bus_addr[PAGE_BITS-1:0]};
	assign req.wdata    = bus_wdata;
	assign req.wr_stb   = wr_stb;

	// Held-low enable must not repeat the write
	a_single_strobe: assert property (
		@(posedge clk_sys) disable iff (rst)
		wr_stb |=> !wr_stb
	);

endmodule

/* hw/page_req_if.sv */
// Decoded page request bundle
interface page_req_if import elk_pkg::*; ();

	// All fields are combinational from the bus, in the clk_sys domain

	// Which store the current bus address hits
	bank_kind_t  kind;
	// Store addresses, page number on top of the page offset
	store_addr_t rom_addr;
	store_addr_t ram_addr;
	// Bus write data, passed straight on
	data_t       wdata;
	// One cycle per falling edge of the write enable
	logic        wr_stb;

	// Decoder side
	modport dec (
		output kind,
		output rom_addr,
		output ram_addr,
		output wdata,
		output wr_stb
	);

	// ROM only needs its address, writes come from the download port
	modport rom (
		input rom_addr
	);

	// Sideways RAM
	modport ram (
		input kind,
		input ram_addr,
		input wdata,
		input wr_stb
	);

	// Read mux
	modport mux (
		input kind
	);

endinterface

/* hw/elk_pkg.sv */
// Electron memory map definitions
package elk_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////////////////////////////////////////

	// External bus of the computer core
	localparam int BUS_AW   = 19;
	localparam int DATA_W   = 8;

	// 16 KiB pages
	localparam int PAGE_BITS = 14;
	localparam int STORE_AW  = 17;

	// Page select field is bus bits 18 to 14
	localparam int PAGE_SEL_W = BUS_AW - PAGE_BITS;
	// Page number inside one store
	localparam int PAGE_NUM_W = STORE_AW - PAGE_BITS;

	localparam int ROM_PAGES = 7;
	localparam int RAM_PAGES = 8;

	// Store depths in bytes
	localparam int ROM_WORDS = ROM_PAGES << PAGE_BITS;
	localparam int RAM_WORDS = RAM_PAGES << PAGE_BITS;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [BUS_AW-1:0]     bus_addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [STORE_AW-1:0]   store_addr_t;
	typedef logic [PAGE_SEL_W-1:0] page_sel_t;
	typedef logic [PAGE_NUM_W-1:0] page_num_t;

	// Store selected by a bus address
	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_ROM,
		BANK_RAM
	} bank_kind_t;

	////////////////////////////////////////////////////////////////////////////
	// Page map, select field grouped 1_2_2
	////////////////////////////////////////////////////////////////////////////

	// Single sideways ROM slot
	localparam page_sel_t PG_SWR_ROM = 5'b0_01_00;
	// OS and BASIC, each mirrored over two slots
	localparam logic [2:0] GRP_OS_BASIC = 3'b0_10;
	// Four upper ROM slots, one page each
	localparam logic [2:0] GRP_HIGH_ROM = 3'b0_11;
	// Sideways RAM, bit 17 clear
	localparam logic [1:0] GRP_SWRAM = 2'b1_0;

	// ROM page numbers
	localparam page_num_t ROM_PG_SWR  = 3'd0;
	localparam page_num_t ROM_PG_OS   = 3'd1;
	localparam page_num_t ROM_PG_HIGH = 3'd3;

endpackage
